/* verilog.f */
+incdir+common
common/mips_isa_pkg.sv
common/decode_ctl_pkg.sv
decode/special_decode.sv
decode/opcode_decode.sv
decode/decode_output_stage.sv
hdl/id_stage.sv
dv/id_stage_asserts.sv
dv/tb_id_stage.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SOURCES   := $(wildcard common/* decode/* hdl/* dv/*)
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM)
	$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* dv/tb_id_stage.sv */
`include "mips_defines.svh"

module tb_id_stage;
    import mips_isa_pkg::*;
    import decode_ctl_pkg::*;

    typedef struct packed {
        ctl_t      ctl;
        reg_addr_t a;
        reg_addr_t b;
        reg_addr_t d;
        logic      ri;
    } result_t;

    localparam int stim_cycles = 600;

    logic      clk = 1'b0;
    logic      arst_n;
    logic      in_valid;
    word_t     instr;
    logic      out_valid;
    ctl_t      ctl;
    reg_addr_t srcrega;
    reg_addr_t srcregb;
    reg_addr_t destreg;
    logic      exception_ri;

    logic [31:0] lfsr_state;
    int          cycle_no;
    int          guard;
    word_t       w;
    result_t     held;
    result_t     exp_q[$];
    int          due_q[$];
    func_t       legal_funcs [23];
    opcode_t     legal_ops [23];

    id_stage dut0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .instr        (instr),
        .out_valid    (out_valid),
        .ctl          (ctl),
        .srcrega      (srcrega),
        .srcregb      (srcregb),
        .destreg      (destreg),
        .exception_ri (exception_ri)
    );

    always #5 clk = ~clk;

    // Galois LFSR stepped once per bit handed out.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
        end
        return r;
    endfunction

    function automatic word_t make_instr();
        logic [1:0]  cls;
        logic [1:0]  code;
        logic [25:0] body;
        int          idx;
        cls  = 2'(rand_bits(2));
        body = 26'(rand_bits(26));
        case (cls)
            2'd0: begin
                idx = rand_bits(5) % 23;
                return {`OP_SPECIAL, body[25:6], legal_funcs[idx]};
            end
            2'd1: begin
                idx = rand_bits(5) % 23;
                return {legal_ops[idx], body};
            end
            2'd2: begin
                code = 2'(rand_bits(2));
                if (rand_bits(1) != 0) begin // Otherwise keep a random, mostly reserved, rt.
                    body[20:16] = {code[1], 3'b000, code[0]};
                end
                return {`OP_REGIMM, body};
            end
            default: return rand_bits(32);
        endcase
    endfunction

    function automatic alu_func_t func_alu(input func_t fn);
        case (fn)
            `F_ADD:          return `ALU_ADD;
            `F_ADDU:         return `ALU_ADDU;
            `F_SUB:          return `ALU_SUB;
            `F_SUBU:         return `ALU_SUBU;
            `F_SLT:          return `ALU_SLT;
            `F_SLTU:         return `ALU_SLTU;
            `F_AND:          return `ALU_AND;
            `F_OR:           return `ALU_OR;
            `F_XOR:          return `ALU_XOR;
            `F_NOR:          return `ALU_NOR;
            `F_SLL, `F_SLLV: return `ALU_SLL;
            `F_SRL, `F_SRLV: return `ALU_SRL;
            `F_SRA, `F_SRAV: return `ALU_SRA;
            `F_MOVZ:         return `ALU_MOVZ;
            `F_MOVN:         return `ALU_MOVN;
            default:         return `ALU_PASSA; // Jumps and traps pass rs through.
        endcase
    endfunction

    function automatic result_t model_decode(input word_t iw);
        result_t   e;
        opcode_t   op;
        func_t     fn;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        mem_size_t size;
        op = iw[31:26];
        fn = iw[5:0];
        rs = iw[25:21];
        rt = iw[20:16];
        rd = iw[15:11];
        e  = '0;
        case (op)
            `OP_LB, `OP_LBU, `OP_SB: size = `MEM_BYTE;
            `OP_LH, `OP_LHU, `OP_SH: size = `MEM_HALF;
            default:                 size = `MEM_WORD;
        endcase
        if (op == `OP_SPECIAL) begin
            case (fn)
                `F_SLL, `F_SRL, `F_SRA: begin
                    e.ctl.shamt_valid = 1'b1;
                    e.ctl.regwrite    = 1'b1;
                    e.b = rt;
                    e.d = rd;
                end
                `F_SLLV, `F_SRLV, `F_SRAV, `F_MOVZ, `F_MOVN, `F_ADD, `F_ADDU, `F_SUB,
                `F_SUBU, `F_AND, `F_OR, `F_XOR, `F_NOR, `F_SLT, `F_SLTU: begin
                    e.ctl.regwrite = 1'b1;
                    e.a = rs;
                    e.b = rt;
                    e.d = rd;
                end
                `F_JR, `F_JALR: begin
                    e.ctl.jump = 1'b1;
                    e.ctl.jr   = 1'b1;
                    e.a = rs;
                    if (fn == `F_JALR) begin
                        e.ctl.regwrite = 1'b1;
                        e.ctl.is_link  = 1'b1;
                        e.d = `LINK_REG;
                    end
                end
                `F_SYSCALL: e.ctl.is_sys = 1'b1;
                `F_BREAK:   e.ctl.is_bp  = 1'b1;
                `F_SYNC: begin
                end
                default: e.ri = 1'b1;
            endcase
            if (!e.ri && fn != `F_SYNC) begin
                e.ctl.alufunc = func_alu(fn);
            end
        end else begin
            case (op)
                `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
                `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI: begin
                    case (op)
                        `OP_ADDI:  e.ctl.alufunc = `ALU_ADD;
                        `OP_ADDIU: e.ctl.alufunc = `ALU_ADDU;
                        `OP_SLTI:  e.ctl.alufunc = `ALU_SLT;
                        `OP_SLTIU: e.ctl.alufunc = `ALU_SLTU;
                        `OP_ANDI:  e.ctl.alufunc = `ALU_AND;
                        `OP_ORI:   e.ctl.alufunc = `ALU_OR;
                        `OP_XORI:  e.ctl.alufunc = `ALU_XOR;
                        default:   e.ctl.alufunc = `ALU_LUI;
                    endcase
                    e.ctl.alusrc_imm = 1'b1;
                    e.ctl.regwrite   = 1'b1;
                    e.ctl.zeroext    = op inside {`OP_ANDI, `OP_ORI, `OP_XORI};
                    e.a = (op == `OP_LUI) ? 5'd0 : rs;
                    e.d = rt;
                end
                `OP_BEQ, `OP_BNE: begin
                    e.ctl.branch      = 1'b1;
                    e.ctl.branch_type = (op == `OP_BEQ) ? `BR_BEQ : `BR_BNE;
                    e.a = rs;
                    e.b = rt;
                end
                `OP_BGTZ, `OP_BLEZ: begin
                    e.ctl.branch      = 1'b1;
                    e.ctl.branch_type = (op == `OP_BGTZ) ? `BR_BGTZ : `BR_BLEZ;
                    e.a = rs;
                end
                `OP_REGIMM: begin
                    if (rt inside {`B_BLTZ, `B_BGEZ, `B_BLTZAL, `B_BGEZAL}) begin
                        e.ctl.branch      = 1'b1;
                        e.ctl.branch_type = (rt inside {`B_BGEZ, `B_BGEZAL}) ? `BR_BGEZ : `BR_BLTZ;
                        e.a = rs;
                        if (rt inside {`B_BLTZAL, `B_BGEZAL}) begin
                            e.ctl.regwrite = 1'b1;
                            e.ctl.is_link  = 1'b1;
                            e.d = `LINK_REG;
                        end
                    end else begin
                        e.ri = 1'b1;
                    end
                end
                `OP_J: e.ctl.jump = 1'b1;
                `OP_JAL: begin
                    e.ctl.jump     = 1'b1;
                    e.ctl.regwrite = 1'b1;
                    e.ctl.is_link  = 1'b1;
                    e.d = `LINK_REG;
                end
                `OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU: begin
                    e.ctl.alusrc_imm   = 1'b1;
                    e.ctl.regwrite     = 1'b1;
                    e.ctl.memtoreg     = 1'b1;
                    e.ctl.mem_size     = size;
                    e.ctl.mem_unsigned = op inside {`OP_LBU, `OP_LHU};
                    e.a = rs;
                    e.d = rt;
                end
                `OP_SB, `OP_SH, `OP_SW: begin
                    e.ctl.alusrc_imm = 1'b1;
                    e.ctl.memwrite   = 1'b1;
                    e.ctl.mem_size   = size;
                    e.a = rs;
                    e.b = rt;
                end
                `OP_PREF: begin
                end
                default: e.ri = 1'b1;
            endcase
        end
        return e;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_ctl(input ctl_t got, input ctl_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL at %0t: ctl is %h, expected %h", $time, got, exp));
        end
    endtask

    task automatic check_reg(input reg_addr_t got, input reg_addr_t exp, input string name);
        if (got !== exp) begin
            abort_run($sformatf("FAIL at %0t: %s is %0d, expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL at %0t: exception_ri is %b, expected %b", $time, got, exp));
        end
    endtask

    // Outputs are sampled mid-cycle, away from the edge that drives them.
    always @(negedge clk) begin
        cycle_no = cycle_no + 1;
        if (out_valid) begin
            if (due_q.size() == 0 || due_q[0] != cycle_no) begin
                abort_run($sformatf("out_valid was high at %0t with no result due then", $time));
            end
            held = exp_q.pop_front();
            void'(due_q.pop_front());
        end else if (due_q.size() != 0 && due_q[0] <= cycle_no) begin
            abort_run($sformatf("out_valid stayed low at %0t although a result was due", $time));
        end
        check_ctl(ctl, held.ctl);
        check_reg(srcrega, held.a, "srcrega");
        check_reg(srcregb, held.b, "srcregb");
        check_reg(destreg, held.d, "destreg");
        check_flag(exception_ri, held.ri);
    end

    initial begin
        legal_funcs = '{`F_SLL, `F_SRL, `F_SRA, `F_SLLV, `F_SRLV, `F_SRAV, `F_JR, `F_JALR,
                        `F_MOVZ, `F_MOVN, `F_SYSCALL, `F_BREAK, `F_SYNC, `F_ADD, `F_ADDU,
                        `F_SUB, `F_SUBU, `F_AND, `F_OR, `F_XOR, `F_NOR, `F_SLT, `F_SLTU};
        legal_ops = '{`OP_J, `OP_JAL, `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ, `OP_ADDI, `OP_ADDIU,
                      `OP_SLTI, `OP_SLTIU, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI, `OP_LB,
                      `OP_LH, `OP_LW, `OP_LBU, `OP_LHU, `OP_SB, `OP_SH, `OP_SW, `OP_PREF};
        lfsr_state = 32'd34;
        cycle_no   = 0;
        held       = '0;
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        instr      = '0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        repeat (2) @(posedge clk);
        repeat (stim_cycles) begin
            @(posedge clk);
            if (rand_bits(2) != 0) begin
                w = make_instr();
                in_valid <= 1'b1;
                instr    <= w;
                exp_q.push_back(model_decode(w));
                due_q.push_back(cycle_no + 2); // Seen at the second falling edge from now.
            end else begin
                in_valid <= 1'b0;
                instr    <= rand_bits(32);
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
        guard = 0;
        while (due_q.size() != 0 && guard < 10) begin
            @(posedge clk);
            guard++;
        end
        if (due_q.size() != 0) begin
            abort_run("timed out waiting for out_valid of the last instructions");
        end else begin
            repeat (2) @(posedge clk);
            $display("Verification passed");
            $finish;
        end
    end

endmodule

/* dv/id_stage_asserts.sv */
module id_stage_asserts (
    input logic                    clk,
    input logic                    arst_n,
    input logic                    in_valid,
    input logic                    out_valid,
    input decode_ctl_pkg::ctl_t    ctl,
    input mips_isa_pkg::reg_addr_t destreg,
    input logic                    exception_ri
);

    valid_follows_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid == $past(in_valid))
        else $error("out_valid does not follow in_valid by one cycle");

    // A reserved instruction must never change architectural state.
    reserved_is_inert: assert property (@(posedge clk) disable iff (!arst_n)
        exception_ri |-> (!ctl.regwrite && !ctl.memwrite))
        else $error("reserved instruction writes a register or memory");

    dest_zero_without_write: assert property (@(posedge clk) disable iff (!arst_n)
        !ctl.regwrite |-> (destreg == '0))
        else $error("destreg is nonzero while regwrite is low");

endmodule

bind id_stage id_stage_asserts asserts0 (
    .clk          (clk),
    .arst_n       (arst_n),
    .in_valid     (in_valid),
    .out_valid    (out_valid),
    .ctl          (ctl),
    .destreg      (destreg),
    .exception_ri (exception_ri)
);

/* hdl/id_stage.sv */
module id_stage (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     in_valid,
    input  mips_isa_pkg::word_t      instr,
    output logic                     out_valid,
    output decode_ctl_pkg::ctl_t     ctl,
    output mips_isa_pkg::reg_addr_t  srcrega,
    output mips_isa_pkg::reg_addr_t  srcregb,
    output mips_isa_pkg::reg_addr_t  destreg,
    output logic                     exception_ri
);
    import decode_ctl_pkg::*;

    dec_t special_dec;
    dec_t dec;

    special_decode special_decode0 (
        .instr (instr),
        .dec   (special_dec)
    );

    opcode_decode opcode_decode0 (
        .instr       (instr),
        .special_dec (special_dec),
        .dec         (dec)
    );

    decode_output_stage decode_output_stage0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .instr        (instr),
        .dec          (dec),
        .out_valid    (out_valid),
        .ctl          (ctl),
        .srcrega      (srcrega),
        .srcregb      (srcregb),
        .destreg      (destreg),
        .exception_ri (exception_ri)
    );

endmodule

/* decode/decode_output_stage.sv */
`include "mips_defines.svh"

module decode_output_stage (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     in_valid,
    input  mips_isa_pkg::word_t      instr,
    input  decode_ctl_pkg::dec_t     dec,
    output logic                     out_valid,
    output decode_ctl_pkg::ctl_t     ctl,
    output mips_isa_pkg::reg_addr_t  srcrega,
    output mips_isa_pkg::reg_addr_t  srcregb,
    output mips_isa_pkg::reg_addr_t  destreg,
    output logic                     exception_ri
);
    import mips_isa_pkg::*;

    reg_addr_t addr_a;
    reg_addr_t addr_b;
    reg_addr_t addr_d;

    assign addr_a = (dec.sel_a == `SEL_A_RS) ? instr[`INSTR_RS] : '0;
    assign addr_b = (dec.sel_b == `SEL_B_RT) ? instr[`INSTR_RT] : '0;

    always_comb begin
        case (dec.sel_dest)
            `SEL_D_RT:   addr_d = instr[`INSTR_RT];
            `SEL_D_RD:   addr_d = instr[`INSTR_RD];
            `SEL_D_LINK: addr_d = `LINK_REG;
            default:     addr_d = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid    <= 1'b0;
            ctl          <= '0;
            srcrega      <= '0;
            srcregb      <= '0;
            destreg      <= '0;
            exception_ri <= 1'b0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin // Outputs hold between strobes.
                ctl          <= dec.ctl;
                srcrega      <= addr_a;
                srcregb      <= addr_b;
                destreg      <= addr_d;
                exception_ri <= dec.reserved;
            end
        end
    end

endmodule

/* decode/opcode_decode.sv */
`include "mips_defines.svh"

module opcode_decode (
    input  mips_isa_pkg::word_t  instr,
    input  decode_ctl_pkg::dec_t special_dec,
    output decode_ctl_pkg::dec_t dec
);
    import mips_isa_pkg::*;
    import decode_ctl_pkg::*;

    opcode_t   op;
    reg_addr_t regimm;

    function automatic alu_func_t imm_alu(input opcode_t o);
        case (o)
            `OP_ADDI:  return `ALU_ADD;
            `OP_ADDIU: return `ALU_ADDU;
            `OP_SLTI:  return `ALU_SLT;
            `OP_SLTIU: return `ALU_SLTU;
            `OP_ANDI:  return `ALU_AND;
            `OP_ORI:   return `ALU_OR;
            `OP_XORI:  return `ALU_XOR;
            default:   return `ALU_LUI;
        endcase
    endfunction

    // Low opcode bits give the access size for both loads and stores.
    function automatic mem_size_t mem_size_of(input opcode_t o);
        case (o[1:0])
            2'b00:   return `MEM_BYTE;
            2'b01:   return `MEM_HALF;
            default: return `MEM_WORD;
        endcase
    endfunction

    assign op     = instr[`INSTR_OP];
    assign regimm = instr[`INSTR_RT];

    always_comb begin
        dec = '0;
        case (op)
            `OP_SPECIAL: dec = special_dec;
            `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
            `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI: begin
                dec.ctl.alufunc    = imm_alu(op);
                dec.ctl.alusrc_imm = 1'b1;
                dec.ctl.regwrite   = 1'b1;
                dec.ctl.zeroext    = (op == `OP_ANDI) || (op == `OP_ORI) || (op == `OP_XORI);
                dec.sel_a          = (op == `OP_LUI) ? `SEL_A_ZERO : `SEL_A_RS;
                dec.sel_dest       = `SEL_D_RT;
            end
            `OP_BEQ, `OP_BNE: begin
                dec.ctl.branch      = 1'b1;
                dec.ctl.branch_type = (op == `OP_BEQ) ? `BR_BEQ : `BR_BNE;
                dec.sel_a           = `SEL_A_RS;
                dec.sel_b           = `SEL_B_RT;
            end
            `OP_BGTZ, `OP_BLEZ: begin
                dec.ctl.branch      = 1'b1;
                dec.ctl.branch_type = (op == `OP_BGTZ) ? `BR_BGTZ : `BR_BLEZ;
                dec.sel_a           = `SEL_A_RS;
            end
            `OP_REGIMM: begin
                case (regimm)
                    `B_BLTZ, `B_BGEZ, `B_BLTZAL, `B_BGEZAL: begin
                        dec.ctl.branch      = 1'b1;
                        dec.ctl.branch_type = regimm[0] ? `BR_BGEZ : `BR_BLTZ;
                        dec.sel_a           = `SEL_A_RS;
                        if (regimm[4]) begin // Linking forms.
                            dec.ctl.regwrite = 1'b1;
                            dec.ctl.is_link  = 1'b1;
                            dec.sel_dest     = `SEL_D_LINK;
                        end
                    end
                    default: dec.reserved = 1'b1;
                endcase
            end
            `OP_J, `OP_JAL: begin
                dec.ctl.jump = 1'b1;
                if (op == `OP_JAL) begin
                    dec.ctl.regwrite = 1'b1;
                    dec.ctl.is_link  = 1'b1;
                    dec.sel_dest     = `SEL_D_LINK;
                end
            end
            `OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU: begin
                dec.ctl.alusrc_imm   = 1'b1;
                dec.ctl.regwrite     = 1'b1;
                dec.ctl.memtoreg     = 1'b1;
                dec.ctl.mem_size     = mem_size_of(op);
                dec.ctl.mem_unsigned = op[2]; // Set only for LBU and LHU.
                dec.sel_a            = `SEL_A_RS;
                dec.sel_dest         = `SEL_D_RT;
            end
            `OP_SB, `OP_SH, `OP_SW: begin
                dec.ctl.alusrc_imm = 1'b1;
                dec.ctl.memwrite   = 1'b1;
                dec.ctl.mem_size   = mem_size_of(op);
                dec.sel_a          = `SEL_A_RS;
                dec.sel_b          = `SEL_B_RT;
            end
            `OP_PREF: begin
            end
            default: dec.reserved = 1'b1;
        endcase
    end

endmodule

/* decode/special_decode.sv */
`include "mips_defines.svh"

module special_decode (
    input  mips_isa_pkg::word_t  instr,
    output decode_ctl_pkg::dec_t dec
);
    import mips_isa_pkg::*;
    import decode_ctl_pkg::*;

    func_t func;

    function automatic alu_func_t alu_code(input func_t f);
        case (f)
            `F_ADD:                        return `ALU_ADD;
            `F_ADDU:                       return `ALU_ADDU;
            `F_SUB:                        return `ALU_SUB;
            `F_SUBU:                       return `ALU_SUBU;
            `F_SLT:                        return `ALU_SLT;
            `F_SLTU:                       return `ALU_SLTU;
            `F_AND:                        return `ALU_AND;
            `F_OR:                         return `ALU_OR;
            `F_XOR:                        return `ALU_XOR;
            `F_NOR:                        return `ALU_NOR;
            `F_SLL, `F_SLLV:               return `ALU_SLL;
            `F_SRL, `F_SRLV:               return `ALU_SRL;
            `F_SRA, `F_SRAV:               return `ALU_SRA;
            `F_MOVZ:                       return `ALU_MOVZ;
            `F_MOVN:                       return `ALU_MOVN;
            `F_JR, `F_JALR:                return `ALU_PASSA;
            `F_SYSCALL, `F_BREAK:          return `ALU_PASSA;
            default:                       return '0;
        endcase
    endfunction

    assign func = instr[`INSTR_FUNC];

    always_comb begin
        dec = '0;
        dec.ctl.alufunc = alu_code(func);
        case (func)
            `F_SLL, `F_SRL, `F_SRA: begin
                dec.ctl.shamt_valid = 1'b1; // Shift amount comes from the instruction.
                dec.ctl.regwrite    = 1'b1;
                dec.sel_b           = `SEL_B_RT;
                dec.sel_dest        = `SEL_D_RD;
            end
            `F_SLLV, `F_SRLV, `F_SRAV, `F_MOVZ, `F_MOVN,
            `F_ADD, `F_ADDU, `F_SUB, `F_SUBU, `F_SLT, `F_SLTU,
            `F_AND, `F_OR, `F_XOR, `F_NOR: begin
                dec.ctl.regwrite = 1'b1;
                dec.sel_a        = `SEL_A_RS;
                dec.sel_b        = `SEL_B_RT;
                dec.sel_dest     = `SEL_D_RD;
            end
            `F_JR, `F_JALR: begin
                dec.ctl.jump = 1'b1;
                dec.ctl.jr   = 1'b1;
                dec.sel_a    = `SEL_A_RS;
                if (func == `F_JALR) begin
                    dec.ctl.regwrite = 1'b1;
                    dec.ctl.is_link  = 1'b1;
                    dec.sel_dest     = `SEL_D_LINK; // Return address always goes to r31.
                end
            end
            `F_SYSCALL: dec.ctl.is_sys = 1'b1;
            `F_BREAK:   dec.ctl.is_bp  = 1'b1;
            `F_SYNC: begin
            end
            default: dec.reserved = 1'b1; // The function already mapped alufunc to zero.
        endcase
    end

endmodule

/* common/decode_ctl_pkg.sv */
package decode_ctl_pkg;

    typedef logic [4:0] alu_func_t;
    typedef logic [2:0] branch_type_t;
    typedef logic [1:0] mem_size_t;
    typedef logic [1:0] reg_sel_t;

    typedef struct packed {
        alu_func_t    alufunc;
        logic         alusrc_imm;
        logic         zeroext;
        logic         shamt_valid;
        logic         regwrite;
        logic         memtoreg;
        logic         memwrite;
        mem_size_t    mem_size;
        logic         mem_unsigned;
        logic         branch;
        branch_type_t branch_type;
        logic         jump;
        logic         jr;
        logic         is_link;
        logic         is_sys;
        logic         is_bp;
    } ctl_t;

    // Register selectors are resolved to addresses in the output stage.
    typedef struct packed {
        ctl_t     ctl;
        logic     reserved;
        reg_sel_t sel_a;
        reg_sel_t sel_b;
        reg_sel_t sel_dest;
    } dec_t;

endpackage

/* common/mips_isa_pkg.sv */
package mips_isa_pkg;

    typedef logic [31:0] word_t;

    typedef logic [5:0] opcode_t;

    typedef logic [5:0] func_t;

    typedef logic [4:0] reg_addr_t;

endpackage

/* common/mips_defines.svh */
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

`define INSTR_OP     31:26
`define INSTR_RS     25:21
`define INSTR_RT     20:16
`define INSTR_RD     15:11
`define INSTR_FUNC   5:0

`define LINK_REG     5'd31

`define OP_SPECIAL   6'b000000
`define OP_REGIMM    6'b000001
`define OP_J         6'b000010
`define OP_JAL       6'b000011
`define OP_BEQ       6'b000100
`define OP_BNE       6'b000101
`define OP_BLEZ      6'b000110
`define OP_BGTZ      6'b000111
`define OP_ADDI      6'b001000
`define OP_ADDIU     6'b001001
`define OP_SLTI      6'b001010
`define OP_SLTIU     6'b001011
`define OP_ANDI      6'b001100
`define OP_ORI       6'b001101
`define OP_XORI      6'b001110
`define OP_LUI       6'b001111
`define OP_LB        6'b100000
`define OP_LH        6'b100001
`define OP_LW        6'b100011
`define OP_LBU       6'b100100
`define OP_LHU       6'b100101
`define OP_SB        6'b101000
`define OP_SH        6'b101001
`define OP_SW        6'b101011
`define OP_PREF      6'b110011

`define F_SLL        6'b000000
`define F_SRL        6'b000010
`define F_SRA        6'b000011
`define F_SLLV       6'b000100
`define F_SRLV       6'b000110
`define F_SRAV       6'b000111
`define F_JR         6'b001000
`define F_JALR       6'b001001
`define F_MOVZ       6'b001010
`define F_MOVN       6'b001011
`define F_SYSCALL    6'b001100
`define F_BREAK      6'b001101
`define F_SYNC       6'b001111
`define F_ADD        6'b100000
`define F_ADDU       6'b100001
`define F_SUB        6'b100010
`define F_SUBU       6'b100011
`define F_AND        6'b100100
`define F_OR         6'b100101
`define F_XOR        6'b100110
`define F_NOR        6'b100111
`define F_SLT        6'b101010
`define F_SLTU       6'b101011

// REGIMM codes sit in the rt field.
`define B_BLTZ       5'b00000
`define B_BGEZ       5'b00001
`define B_BLTZAL     5'b10000
`define B_BGEZAL     5'b10001

`define ALU_ADD      5'd0
`define ALU_ADDU     5'd1
`define ALU_SUB      5'd2
`define ALU_SUBU     5'd3
`define ALU_SLT      5'd4
`define ALU_SLTU     5'd5
`define ALU_AND      5'd6
`define ALU_OR       5'd7
`define ALU_XOR      5'd8
`define ALU_NOR      5'd9
`define ALU_SLL      5'd10
`define ALU_SRL      5'd11
`define ALU_SRA      5'd12
`define ALU_LUI      5'd13
`define ALU_PASSA    5'd14
`define ALU_MOVZ     5'd15
`define ALU_MOVN     5'd16

// Zero means no branch.
`define BR_BEQ       3'd1
`define BR_BNE       3'd2
`define BR_BGEZ      3'd3
`define BR_BLTZ      3'd4
`define BR_BGTZ      3'd5
`define BR_BLEZ      3'd6

`define MEM_BYTE     2'd1
`define MEM_HALF     2'd2
`define MEM_WORD     2'd3

`define SEL_A_ZERO   2'd0
`define SEL_A_RS     2'd1
`define SEL_B_ZERO   2'd0
`define SEL_B_RT     2'd1
`define SEL_D_ZERO   2'd0
`define SEL_D_RT     2'd1
`define SEL_D_RD     2'd2
`define SEL_D_LINK   2'd3

`endif
